// ==== src.f ====
rtl/mwr_tx_pkg.sv
rtl/mwr_decode.sv
rtl/trn_tx_framer.sv
rtl/tx_result.sv
rtl/mwr_tx_top.sv
testbench/tb_mwr_tx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; exit status reports the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/10ps --top-module tb_mwr_tx \
  -f src.f -o sim_mwr_tx \
  && ./obj_dir/sim_mwr_tx \
  && echo "Simulation passed" \
  || { echo "Simulation reported an error" >&2; exit 1; }

exit 0

// ==== testbench/tb_mwr_tx.sv ====
`timescale 1ns/10ps

module tb_mwr_tx;

  import mwr_tx_pkg::*;

  localparam int NUM_TESTS       = 13;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (int'(TX_TIMEOUT_CYCLES) + 40);

  logic        trn_clk;
  logic        reset;
  logic        req;
  mwr_req_t    mwr_req;
  logic [7:0]  cfg_bus_number;
  logic [4:0]  cfg_device_number;
  logic [2:0]  cfg_function_number;
  logic        ack;
  tx_status_t  status;
  logic        trn_lnk_up_n;
  logic [5:0]  trn_tbuf_av;
  logic        trn_tdst_rdy_n;
  logic        trn_terr_drop_n;
  logic        trn_cyc_n;
  logic [63:0] trn_td;
  logic        trn_tsof_n;
  logic        trn_teof_n;
  logic        trn_trem_n;
  logic        trn_tsrc_rdy_n;

  integer      seed = 32'h3175_5693;
  int          rdy_mode;     // 0 always ready, 1 random, 2 stalled
  tlp_frame_t  exp_frame;
  logic        exp_timeout;
  logic        ack_seen;
  int          n_checked;
  int          tx_expected;
  int          to_expected;
  int          drop_cycles;
  logic [63:0] beat_q[$];
  logic        sof_n_q[$];
  logic        eof_n_q[$];
  logic        rem_n_q[$];

  mwr_tx_top dut (.*);

  // Expected TLP image from the PCIe MWr header layout
  function automatic tlp_frame_t expected_frame(input logic [63:0] addr,
      input logic [31:0] data, input logic [7:0] bus, input logic [4:0] dev,
      input logic [2:0] fn);
    tlp_frame_t f;
    logic [31:0] dw0;
    logic [31:0] dw1;
    logic        four_dw;
    four_dw    = (addr[63:32] != 32'h0);
    dw0        = 32'h0;          // TC0 without TD or EP
    dw0[31:29] = four_dw ? 3'b011 : 3'b010;  // fmt with data
    dw0[28:24] = 5'b00000;       // Memory request
    dw0[13:12] = 2'b01;          // No snoop
    dw0[9:0]   = 10'd1;
    dw1        = {bus, dev, fn, 8'h00, 4'h0, 4'hf};  // Tag 0 and a full first DW
    f          = '0;
    f.beat[0]  = {dw0, dw1};
    if (four_dw) begin
      f.beat[1]    = {addr[63:2], 2'b00};
      f.beat[2]    = {data, 32'h0};
      f.num_beats  = 2'd3;
      f.last_rem_n = 1'b1;
    end else begin
      f.beat[1]    = {addr[31:2], 2'b00, data};
      f.num_beats  = 2'd2;
      f.last_rem_n = 1'b0;
    end
    return f;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
      input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
      $display("Test failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic do_write(input logic [63:0] addr, input logic [31:0] data,
      input logic stall);
    exp_frame   = expected_frame(addr, data, cfg_bus_number, cfg_device_number,
                                 cfg_function_number);
    exp_timeout = stall;
    beat_q.delete();
    sof_n_q.delete();
    eof_n_q.delete();
    rem_n_q.delete();
    @(negedge trn_clk);
    mwr_req.addr = addr;
    mwr_req.data = data;
    req          = 1'b1;
    do @(negedge trn_clk); while (!ack);
    req = 1'b0;
    do @(negedge trn_clk); while (ack);
    if (stall) to_expected++;
    else tx_expected++;
  endtask

  task automatic hold_drop(input int cycles);
    repeat (cycles) begin
      @(negedge trn_clk);
      trn_terr_drop_n = 1'b0;
      drop_cycles++;
    end
    @(negedge trn_clk);
    trn_terr_drop_n = 1'b1;
  endtask

  initial begin
    trn_clk = 1'b0;
    forever #50 trn_clk = ~trn_clk;
  end

  // TRN sink ready pattern
  initial begin : sink_ready
    logic [31:0] rnd;
    trn_tdst_rdy_n = 1'b0;
    forever begin
      @(negedge trn_clk);
      case (rdy_mode)
        1: begin
          rnd            = $random(seed);
          trn_tdst_rdy_n = rnd[0];
        end
        2:       trn_tdst_rdy_n = 1'b1;
        default: trn_tdst_rdy_n = 1'b0;
      endcase
    end
  end

  // TRN sink beat log
  always @(posedge trn_clk) begin
    if (!reset && !trn_tsrc_rdy_n && !trn_tdst_rdy_n) begin
      beat_q.push_back(trn_td);
      sof_n_q.push_back(trn_tsof_n);
      eof_n_q.push_back(trn_teof_n);
      rem_n_q.push_back(trn_trem_n);
    end
  end

  // Compare logged beats once per ack
  always @(negedge trn_clk) begin : compare_beats
    int last;
    if (ack && !ack_seen) begin
      last = int'(exp_frame.num_beats) - 1;
      check_value("status.timed_out", 64'(status.timed_out), 64'(exp_timeout));
      check_value("trn_cyc_n", 64'(trn_cyc_n), 64'd1);
      check_value("trn_tsrc_rdy_n", 64'(trn_tsrc_rdy_n), 64'd1);
      if (exp_timeout) begin
        check_value("beats logged", 64'(beat_q.size()), 64'd0);
      end else begin
        check_value("beats logged", 64'(beat_q.size()), 64'(exp_frame.num_beats));
        for (int i = 0; i <= last; i++) begin
          check_value($sformatf("trn_td beat %0d", i), beat_q[i], exp_frame.beat[i]);
          check_value($sformatf("trn_tsof_n beat %0d", i), 64'(sof_n_q[i]), 64'(i != 0));
          check_value($sformatf("trn_teof_n beat %0d", i), 64'(eof_n_q[i]), 64'(i != last));
        end
        check_value("trn_trem_n last beat", 64'(rem_n_q[last]), 64'(exp_frame.last_rem_n));
      end
      n_checked++;
    end
    ack_seen = ack;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge trn_clk);
    $display("Test failed");
    $fatal(1, "Watchdog expired because a write never completed its handshake");
  end

  initial begin : stimulus
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] dat;
    reset = 1'b1;
    req = 1'b0;
    mwr_req = '0;
    cfg_bus_number = 8'h3a;
    cfg_device_number = 5'h11;
    cfg_function_number = 3'h5;
    trn_lnk_up_n = 1'b0;
    trn_tbuf_av = 6'd8;
    trn_terr_drop_n = 1'b1;
    rdy_mode = 0;
    ack_seen = 1'b0;
    repeat (8) @(negedge trn_clk);
    reset = 1'b0;
    check_value("ack after reset", 64'(ack), 64'd0);
    check_value("trn_cyc_n after reset", 64'(trn_cyc_n), 64'd1);
    check_value("trn_tsrc_rdy_n after reset", 64'(trn_tsrc_rdy_n), 64'd1);
    check_value("trn_tsof_n after reset", 64'(trn_tsof_n), 64'd1);
    check_value("trn_teof_n after reset", 64'(trn_teof_n), 64'd1);
    check_value("status.tx_count after reset", 64'(status.tx_count), 64'd0);
    check_value("status.drop_count after reset", 64'(status.drop_count), 64'd0);
    check_value("status.timeout_count after reset", 64'(status.timeout_count), 64'd0);

    do_write(64'h0000_0000_1234_567b, 32'hcafe_0001, 1'b0);  // 3DW with address bits 1:0 set
    do_write(64'h0000_0012_89ab_cdef, 32'h5a5a_1234, 1'b0);  // 4DW

    rdy_mode = 1;
    for (int i = 0; i < 8; i++) begin
      hi  = $random(seed);
      lo  = $random(seed);
      dat = $random(seed);
      if (i % 2 == 0) hi = 32'h0;
      do_write({hi, lo}, dat, 1'b0);
      if (i == 3) hold_drop(3);
    end
    rdy_mode = 0;

    rdy_mode = 2;
    do_write(64'h0000_0000_0000_1000, 32'hdead_beef, 1'b1);
    rdy_mode = 0;
    hold_drop(2);

    // Requester ID follows the cfg inputs
    cfg_bus_number = 8'hc4;
    cfg_device_number = 5'h03;
    cfg_function_number = 3'h1;
    do_write(64'h0000_0000_8000_0040, 32'h0bad_f00d, 1'b0);
    cfg_bus_number = 8'h01;
    cfg_device_number = 5'h1f;
    cfg_function_number = 3'h7;
    do_write(64'hffff_0000_0000_0008, 32'h1357_9bdf, 1'b0);

    @(negedge trn_clk);
    check_value("status.tx_count", 64'(status.tx_count), 64'(tx_expected));
    check_value("status.timeout_count", 64'(status.timeout_count), 64'(to_expected));
    check_value("status.drop_count", 64'(status.drop_count), 64'(drop_cycles));
    check_value("acks compared", 64'(n_checked), 64'(NUM_TESTS));
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== rtl/mwr_tx_top.sv ====
`timescale 1ns/10ps

module mwr_tx_top (
  input  logic                   trn_clk,
  input  logic                   reset,
  input  logic                   req,
  input  mwr_tx_pkg::mwr_req_t   mwr_req,
  input  logic [7:0]             cfg_bus_number,
  input  logic [4:0]             cfg_device_number,
  input  logic [2:0]             cfg_function_number,
  output logic                   ack,
  output mwr_tx_pkg::tx_status_t status,
  input  logic                   trn_lnk_up_n,
  input  logic [5:0]             trn_tbuf_av,
  input  logic                   trn_tdst_rdy_n,
  input  logic                   trn_terr_drop_n,
  output logic                   trn_cyc_n,
  output logic [63:0]            trn_td,
  output logic                   trn_tsof_n,
  output logic                   trn_teof_n,
  output logic                   trn_trem_n,
  output logic                   trn_tsrc_rdy_n
);

  import mwr_tx_pkg::*;

  logic       busy;
  logic       frame_start;
  tlp_frame_t frame;
  logic       tx_done;
  logic       tx_timed_out;

  mwr_decode u_decode (
    .trn_clk             (trn_clk),
    .reset               (reset),
    .req                 (req),
    .mwr_req             (mwr_req),
    .busy                (busy),
    .cfg_bus_number      (cfg_bus_number),
    .cfg_device_number   (cfg_device_number),
    .cfg_function_number (cfg_function_number),
    .frame_start         (frame_start),
    .frame               (frame)
  );

  trn_tx_framer u_framer (
    .trn_clk        (trn_clk),
    .reset          (reset),
    .frame_start    (frame_start),
    .frame          (frame),
    .trn_lnk_up_n   (trn_lnk_up_n),
    .trn_tbuf_av    (trn_tbuf_av),
    .trn_tdst_rdy_n (trn_tdst_rdy_n),
    .trn_cyc_n      (trn_cyc_n),
    .trn_td         (trn_td),
    .trn_tsof_n     (trn_tsof_n),
    .trn_teof_n     (trn_teof_n),
    .trn_trem_n     (trn_trem_n),
    .trn_tsrc_rdy_n (trn_tsrc_rdy_n),
    .tx_done        (tx_done),
    .tx_timed_out   (tx_timed_out)
  );

  tx_result u_result (
    .trn_clk         (trn_clk),
    .reset           (reset),
    .req             (req),
    .tx_done         (tx_done),
    .tx_timed_out    (tx_timed_out),
    .trn_terr_drop_n (trn_terr_drop_n),
    .busy            (busy),
    .ack             (ack),
    .status          (status)
  );

endmodule

// ==== rtl/tx_result.sv ====
`timescale 1ns/10ps

module tx_result (
  input  logic                   trn_clk,
  input  logic                   reset,
  input  logic                   req,
  input  logic                   tx_done,
  input  logic                   tx_timed_out,
  input  logic                   trn_terr_drop_n,
  output logic                   busy,
  output logic                   ack,
  output mwr_tx_pkg::tx_status_t status
);

  logic release_hs;

  // Host has dropped req after seeing ack
  assign release_hs = ack & ~req;

  always_ff @(posedge trn_clk) begin
    if (reset) begin
      busy <= 1'b0;
      ack  <= 1'b0;
    end else begin
      if (!busy && req) begin
        busy <= 1'b1;
      end else if (release_hs) begin
        busy <= 1'b0;  // Falls together with ack
      end

      if (tx_done) begin
        ack <= 1'b1;
      end else if (release_hs) begin
        ack <= 1'b0;
      end
    end
  end

  always_ff @(posedge trn_clk) begin
    if (reset) begin
      status <= '0;
    end else begin
      if (tx_done) begin
        status.timed_out <= tx_timed_out;  // Held while ack is high
        if (tx_timed_out) begin
          status.timeout_count <= status.timeout_count + 32'd1;
        end else begin
          status.tx_count <= status.tx_count + 32'd1;
        end
      end
      // Each low cycle from the core is one dropped TLP
      if (!trn_terr_drop_n) begin
        status.drop_count <= status.drop_count + 32'd1;
      end
    end
  end

endmodule

// ==== rtl/trn_tx_framer.sv ====
`timescale 1ns/10ps

module trn_tx_framer (
  input  logic                   trn_clk,
  input  logic                   reset,
  input  logic                   frame_start,
  input  mwr_tx_pkg::tlp_frame_t frame,
  input  logic                   trn_lnk_up_n,
  input  logic [5:0]             trn_tbuf_av,
  input  logic                   trn_tdst_rdy_n,
  output logic                   trn_cyc_n,
  output logic [63:0]            trn_td,
  output logic                   trn_tsof_n,
  output logic                   trn_teof_n,
  output logic                   trn_trem_n,
  output logic                   trn_tsrc_rdy_n,
  output logic                   tx_done,
  output logic                   tx_timed_out
);

  import mwr_tx_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT,  // Bus owned while waiting for link and buffer space
    S_SEND
  } state_t;

  state_t     state;
  tlp_frame_t frame_q;
  logic [1:0] beat_idx;
  logic [1:0] next_idx;
  logic [15:0] stall_cnt;
  logic       link_ok;
  logic       accept;
  logic       last_beat;
  logic       next_last;

  assign link_ok   = ~trn_lnk_up_n & (trn_tbuf_av != 6'd0);
  assign accept    = ~trn_tsrc_rdy_n & ~trn_tdst_rdy_n;
  assign next_idx  = beat_idx + 2'd1;
  assign last_beat = (beat_idx == frame_q.num_beats - 2'd1);
  assign next_last = (next_idx == frame_q.num_beats - 2'd1);

  always_ff @(posedge trn_clk) begin
    if (reset) begin
      state          <= S_IDLE;
      beat_idx       <= 2'd0;
      stall_cnt      <= '0;
      trn_cyc_n      <= 1'b1;
      trn_tsof_n     <= 1'b1;
      trn_teof_n     <= 1'b1;
      trn_trem_n     <= 1'b1;
      trn_tsrc_rdy_n <= 1'b1;
      tx_done        <= 1'b0;
      tx_timed_out   <= 1'b0;
    end else begin
      tx_done      <= 1'b0;
      tx_timed_out <= 1'b0;
      case (state)
        S_IDLE: begin
          if (frame_start) begin
            state     <= S_WAIT;
            trn_cyc_n <= 1'b0;
          end
        end
        S_WAIT: begin
          if (link_ok) begin
            // Beat 0 never ends the frame since a TLP has at least two beats
            state          <= S_SEND;
            beat_idx       <= 2'd0;
            stall_cnt      <= '0;
            trn_tsof_n     <= 1'b0;
            trn_teof_n     <= 1'b1;
            trn_trem_n     <= 1'b0;
            trn_tsrc_rdy_n <= 1'b0;
          end
        end
        S_SEND: begin
          if (accept) begin
            stall_cnt <= '0;
            if (last_beat) begin
              state          <= S_IDLE;
              trn_cyc_n      <= 1'b1;
              trn_tsrc_rdy_n <= 1'b1;
              trn_tsof_n     <= 1'b1;
              trn_teof_n     <= 1'b1;
              trn_trem_n     <= 1'b1;
              tx_done        <= 1'b1;
            end else begin
              beat_idx   <= next_idx;
              trn_tsof_n <= 1'b1;
              trn_teof_n <= ~next_last;
              trn_trem_n <= next_last ? frame_q.last_rem_n : 1'b0;
            end
          end else if (stall_cnt == TX_TIMEOUT_CYCLES - 16'd1) begin
            // Give up on this TLP and free the bus
            state          <= S_IDLE;
            stall_cnt      <= '0;
            trn_cyc_n      <= 1'b1;
            trn_tsrc_rdy_n <= 1'b1;
            trn_tsof_n     <= 1'b1;
            trn_teof_n     <= 1'b1;
            trn_trem_n     <= 1'b1;
            tx_done        <= 1'b1;
            tx_timed_out   <= 1'b1;
          end else begin
            stall_cnt <= stall_cnt + 16'd1;  // Current beat held unchanged
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge trn_clk) begin
    if (frame_start && state == S_IDLE) begin
      frame_q <= frame;
    end
    if (state == S_WAIT && link_ok) begin
      trn_td <= frame_q.beat[0];
    end else if (state == S_SEND && accept && !last_beat) begin
      trn_td <= frame_q.beat[next_idx];
    end
  end

endmodule

// ==== rtl/mwr_decode.sv ====
`timescale 1ns/10ps

module mwr_decode (
  input  logic                   trn_clk,
  input  logic                   reset,
  input  logic                   req,
  input  mwr_tx_pkg::mwr_req_t   mwr_req,
  input  logic                   busy,
  input  logic [7:0]             cfg_bus_number,
  input  logic [4:0]             cfg_device_number,
  input  logic [2:0]             cfg_function_number,
  output logic                   frame_start,
  output mwr_tx_pkg::tlp_frame_t frame
);

  import mwr_tx_pkg::*;

  logic       accept;
  logic       is_low_4gb;
  logic [15:0] req_id;
  logic [31:0] hdr_dw0;
  logic [31:0] hdr_dw1;
  tlp_frame_t next_frame;

  // Result stage raises busy on the same edge so accept lasts one cycle
  assign accept     = req & ~busy;
  assign is_low_4gb = (mwr_req.addr[63:32] == 32'h0);
  assign req_id     = {cfg_bus_number, cfg_device_number, cfg_function_number};

  assign hdr_dw0 = {
    is_low_4gb ? MWR_FMT_3DW_DATA : MWR_FMT_4DW_DATA,
    MWR_TYPE_MEM,
    8'h00,              // Reserved bits and TC0
    2'b00,              // TD, EP
    MWR_ATTR_NO_SNOOP,
    2'b00,              // Untranslated address
    MWR_LENGTH_DW
  };

  assign hdr_dw1 = {req_id, 8'h00, MWR_LAST_BE, MWR_FIRST_BE};  // Tag is always 0

  always_comb begin
    next_frame         = '0;
    next_frame.beat[0] = {hdr_dw0, hdr_dw1};
    if (is_low_4gb) begin
      // Address and data share the second beat
      next_frame.beat[1]    = {mwr_req.addr[31:2], 2'b00, mwr_req.data};
      next_frame.num_beats  = 2'd2;
      next_frame.last_rem_n = 1'b0;
    end else begin
      next_frame.beat[1]    = {mwr_req.addr[63:2], 2'b00};
      next_frame.beat[2]    = {mwr_req.data, 32'h0};  // Only upper DW valid
      next_frame.num_beats  = 2'd3;
      next_frame.last_rem_n = 1'b1;
    end
  end

  always_ff @(posedge trn_clk) begin
    if (reset) begin
      frame_start <= 1'b0;
    end else begin
      frame_start <= accept;
    end
  end

  // Frame image handed to the framer with frame_start
  always_ff @(posedge trn_clk) begin
    if (accept) begin
      frame <= next_frame;
    end
  end

endmodule

// ==== rtl/mwr_tx_pkg.sv ====
package mwr_tx_pkg;

  // TLP header DW0 fields
  localparam logic [2:0] MWR_FMT_3DW_DATA  = 3'b010;  // 3DW header with data
  localparam logic [2:0] MWR_FMT_4DW_DATA  = 3'b011;  // 4DW header with data
  localparam logic [4:0] MWR_TYPE_MEM      = 5'b00000;  // Memory request
  localparam logic [1:0] MWR_ATTR_NO_SNOOP = 2'b01;
  localparam logic [9:0] MWR_LENGTH_DW     = 10'd1;  // Single DW payload

  // Header DW1 byte enables for a full first DW only
  localparam logic [3:0] MWR_FIRST_BE = 4'hf;
  localparam logic [3:0] MWR_LAST_BE  = 4'h0;

  // Stall cycles before a TLP is abandoned
  localparam logic [15:0] TX_TIMEOUT_CYCLES = 16'd64;

  // One host write request
  typedef struct packed {
    logic [63:0] addr;
    logic [31:0] data;
  } mwr_req_t;

  // TLP image handed from decode to the framer
  typedef struct packed {
    logic [2:0][63:0] beat;
    logic [1:0]       num_beats;   // 2 or 3
    logic             last_rem_n;  // Low when the last beat is full
  } tlp_frame_t;

  // Completion status and statistics seen by the host
  typedef struct packed {
    logic        timed_out;
    logic [31:0] tx_count;
    logic [31:0] drop_count;
    logic [31:0] timeout_count;
  } tx_status_t;

endpackage
